// File: lightCycle.f
+incdir+.
verilog/sramPkg.sv
verilog/drawPkg.sv
verilog/sramController.sv
verilog/lineFetch.sv
verilog/lightCycleFetch.sv
tb/sramModel.sv
tb/lightCycleFetch_tb.sv

// File: lightCycle_params.svh
// ----------------------------------------
// fixed image layout and SRAM geometry for the fetch path
// include wherever widths or base addresses are needed
// ----------------------------------------
`ifndef LIGHTCYCLE_PARAMS_SVH
`define LIGHTCYCLE_PARAMS_SVH

// external SRAM, word addressed
`define SRAM_AW 20
`define SRAM_DW 16

// one image row is 8 words of 16 bits
`define WORDS_PER_LINE 8
`define WORD_IDX_W 3

// rows per image fit in 9 bits
`define ROW_IDX_W 9

// eight bike sprites
`define SPRITE_IDX_W 3

// image start addresses in words
`define MENU_BASE 20'h00000
`define BG_BASE 20'h01000
`define SPRITE_BASE 20'h02000

// words per sprite image, 64 rows of one line each
`define SPRITE_WORDS 512

`endif

// File: run.sh
#!/bin/sh
# build with Verilator, run, then judge the run by its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lightCycleFetch_tb \
	-f lightCycle.f -o simv > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST OK" sim.log

// File: tb/lightCycleFetch_tb.sv
// ----------------------------------------
// testbench for the image fetch top on a pattern SRAM
// random row requests, assertions do the checking
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "lightCycle_params.svh"

module lightCycleFetch_tb
	import sramPkg::*, drawPkg::*;
();

	localparam int clkPeriod = 20;
	localparam int numRequests = 40;
	// per request budget, plus slack for reset
	localparam int cyclesPerRequest = 40;
	localparam int marginCycles = 100;

	logic Clk;
	logic rst;
	logic start;
	gameState gameSt;
	logic spriteEn;
	spriteIdx spriteSel;
	rowIdx row;
	wordIdx rdIdx;
	sramWord rdWord;
	logic busy;
	logic lineDone;
	logic ce;
	logic ub;
	logic lb;
	logic oe;
	logic we;
	sramAddr sramAddrOut;
	sramWord sramData;

	// expected start address of the row being fetched
	sramAddr curBase;
	// accepted request still waiting for its lineDone
	logic fetchOpen;
	int doneCount;
	logic [31:0] lfsr;

	lightCycleFetch uut
	(
		.Clk(Clk),
		.rst(rst),
		.start(start),
		.gameSt(gameSt),
		.spriteEn(spriteEn),
		.spriteSel(spriteSel),
		.row(row),
		.rdIdx(rdIdx),
		.rdWord(rdWord),
		.busy(busy),
		.lineDone(lineDone),
		.ce(ce),
		.ub(ub),
		.lb(lb),
		.oe(oe),
		.we(we),
		.sramAddrOut(sramAddrOut),
		.sramData(sramData)
	);

	sramModel mem
	(
		.ce(ce),
		.ub(ub),
		.lb(lb),
		.oe(oe),
		.we(we),
		.addr(sramAddrOut),
		.data(sramData)
	);

	always #(clkPeriod / 2) Clk = ~Clk;

	always @(posedge Clk)
	begin
		if (rst)
			doneCount <= 0;
		else if (lineDone)
			doneCount <= doneCount + 1;
	end

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic wrongValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		stopWithFailure($sformatf("error at %0t ns: %s is %h, expected %h",
			$time, name, got, expected));
	endtask

	// x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			bits = {bits[14:0], lfsr[0]};
		end
		return bits;
	endfunction

	// word stored at an address by the SRAM model
	function automatic sramWord patternAt(input sramAddr a);
		return a[15:0] ^ 16'hA5C3 ^ {12'h000, a[19:16]};
	endfunction

	// image base from the layout, then rows of WORDS_PER_LINE words
	function automatic sramAddr rowStart(input gameState gs, input logic spEn,
		input spriteIdx sel, input rowIdx r);
		int image;
		if (gs == gsMenu)
			image = int'(`MENU_BASE);
		else if (spEn)
			image = int'(`SPRITE_BASE) + int'(sel) * `SPRITE_WORDS;
		else
			image = int'(`BG_BASE);
		return sramAddr'(image + int'(r) * `WORDS_PER_LINE);
	endfunction

	// new random request on the inputs, row below 64
	task automatic drawRequest();
		logic [15:0] bits;
		bits = takeBits(1);
		gameSt = bits[0] ? gsPlay : gsMenu;
		bits = takeBits(1);
		spriteEn = bits[0];
		bits = takeBits(3);
		spriteSel = spriteIdx'(bits);
		bits = takeBits(6);
		row = rowIdx'(bits);
	endtask

	// one request, maybe a dropped start, then read back the row
	task automatic requestRow();
		logic [15:0] bits;
		drawRequest();
		curBase = rowStart(gameSt, spriteEn, spriteSel, row);
		fetchOpen = 1'b1;
		start = 1'b1;
		@(negedge Clk);
		start = 1'b0;
		bits = takeBits(5);
		if (bits[4])
		begin
			repeat (int'(bits[3:0]) + 1) @(negedge Clk);
			assert (busy == 1'b1) else wrongValue("busy", 32'(busy), 32'd1);
			// this one must be dropped
			drawRequest();
			start = 1'b1;
			@(negedge Clk);
			start = 1'b0;
		end
		while (!lineDone)
			@(negedge Clk);
		@(negedge Clk);
		fetchOpen = 1'b0;
		// lookup has no clock, so each index is checked before the next rising edge
		for (int i = 0; i < `WORDS_PER_LINE; i++)
		begin
			rdIdx = wordIdx'(i);
			#(clkPeriod / 4);
			assert (busy == 1'b0) else wrongValue("busy", 32'(busy), 32'd0);
			assert (rdWord == patternAt(curBase + sramAddr'(i)))
				else wrongValue("rdWord", 32'(rdWord), 32'(patternAt(curBase + sramAddr'(i))));
			@(negedge Clk);
		end
	endtask

	initial
	begin
		Clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		gameSt = gsMenu;
		spriteEn = 1'b0;
		spriteSel = '0;
		row = '0;
		rdIdx = '0;
		curBase = '0;
		fetchOpen = 1'b0;
		lfsr = 32'h20b5_b7cc;
		repeat (4) @(posedge Clk);
		@(negedge Clk);
		rst = 1'b0;
		// pin and flag levels left by reset
		assert (oe == 1'b1) else wrongValue("oe", 32'(oe), 32'd1);
		assert (we == 1'b1) else wrongValue("we", 32'(we), 32'd1);
		assert (ce == 1'b0) else wrongValue("ce", 32'(ce), 32'd0);
		assert (ub == 1'b0) else wrongValue("ub", 32'(ub), 32'd0);
		assert (lb == 1'b0) else wrongValue("lb", 32'(lb), 32'd0);
		assert (busy == 1'b0) else wrongValue("busy", 32'(busy), 32'd0);
		assert (lineDone == 1'b0) else wrongValue("lineDone", 32'(lineDone), 32'd0);
		repeat (numRequests) requestRow();
		if (doneCount == numRequests)
		begin
			$display("TEST OK");
			$finish;
		end
		else
			wrongValue("doneCount", 32'(doneCount), 32'(numRequests));
	end

	// watchdog
	initial
	begin
		#((numRequests * cyclesPerRequest + marginCycles) * clkPeriod);
		stopWithFailure("timeout: the requests did not all finish in time");
	end

	pinsReadOnly: assert property (@(posedge Clk) we && !ce && !ub && !lb)
		else stopWithFailure("SRAM control pins left the read-only levels");

	oeNeedsBusy: assert property (@(posedge Clk) disable iff (rst) !busy |-> oe)
		else stopWithFailure("oe went low while busy was low");

	busyAfterDone: assert property (@(posedge Clk) disable iff (rst) lineDone |=> !busy)
		else stopWithFailure("busy did not fall after lineDone");

	// unsigned difference also catches addresses below the row
	addrInRow: assert property (@(posedge Clk) disable iff (rst)
		!oe |-> (sramAddrOut - curBase) < sramAddr'(`WORDS_PER_LINE))
		else stopWithFailure("SRAM address outside the requested row");

	doneOwed: assert property (@(posedge Clk) disable iff (rst) lineDone |-> fetchOpen)
		else stopWithFailure("lineDone without an accepted request");

endmodule

`default_nettype wire

// File: tb/sramModel.sv
// ----------------------------------------
// read-only async SRAM stand-in for the testbench
// each word is a fixed pattern of its address
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module sramModel
	import sramPkg::*;
(
	input logic ce,
	input logic ub,
	input logic lb,
	input logic oe,
	input logic we,
	input sramAddr addr,
	output sramWord data
);

	sramWord pattern;
	logic driving;

	// low half xor a constant, top address bits folded in
	assign pattern = addr[15:0] ^ 16'hA5C3 ^ {12'h000, addr[19:16]};

	// output only on a selected read
	assign driving = !ce && !oe && we;

	// byte lanes follow ub and lb, bus parked low when not driven
	assign data = driving
		? {(ub ? 8'h00 : pattern[15:8]), (lb ? 8'h00 : pattern[7:0])}
		: '0;

endmodule

`default_nettype wire

// File: verilog/drawPkg.sv
// ----------------------------------------
// draw side types: image choice, row and word indices, fetch FSM
// ----------------------------------------
`default_nettype none

`include "lightCycle_params.svh"

package drawPkg;

	// which full-screen image the game wants
	typedef enum logic
	{
		gsMenu,
		gsPlay
	} gameState;

	// bike sprite number
	typedef logic [`SPRITE_IDX_W-1:0] spriteIdx;

	// image row number
	typedef logic [`ROW_IDX_W-1:0] rowIdx;

	// word position inside one line
	typedef logic [`WORD_IDX_W-1:0] wordIdx;

	// line fetch sequence
	typedef enum logic [1:0]
	{
		fIdle,
		fIssue,
		fWait,
		fDone
	} fetchState;

endpackage

`default_nettype wire

// File: verilog/lightCycleFetch.sv
// ----------------------------------------
// image fetch top, draw engine plus SRAM read controller
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lightCycleFetch
	import sramPkg::*, drawPkg::*;
(
	input logic Clk,
	input logic rst,
	input logic start,
	input gameState gameSt,
	input logic spriteEn,
	input spriteIdx spriteSel,
	input rowIdx row,
	input wordIdx rdIdx,
	output sramWord rdWord,
	output logic busy,
	output logic lineDone,
	output logic ce,
	output logic ub,
	output logic lb,
	output logic oe,
	output logic we,
	output sramAddr sramAddrOut,
	input sramWord sramData
);

	// engine to controller
	logic read;
	sramAddr addr;
	logic doneR;
	sramWord readData;

	lineFetch fetch
	(
		.Clk(Clk),
		.rst(rst),
		.start(start),
		.gameSt(gameSt),
		.spriteEn(spriteEn),
		.spriteSel(spriteSel),
		.row(row),
		.rdIdx(rdIdx),
		.rdWord(rdWord),
		.busy(busy),
		.lineDone(lineDone),
		.read(read),
		.addr(addr),
		.doneR(doneR),
		.readData(readData)
	);

	// pins go straight out
	sramController ctrl
	(
		.Clk(Clk),
		.rst(rst),
		.read(read),
		.addr(addr),
		.data(sramData),
		.ce(ce),
		.ub(ub),
		.lb(lb),
		.oe(oe),
		.we(we),
		.addrOut(sramAddrOut),
		.doneR(doneR),
		.readData(readData)
	);

endmodule

`default_nettype wire

// File: verilog/lineFetch.sv
// ----------------------------------------
// fetches one image row into an 8-word line buffer
// start with image select and row, wait for lineDone
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "lightCycle_params.svh"

module lineFetch
	import sramPkg::*, drawPkg::*;
(
	input logic Clk,
	input logic rst,
	input logic start,
	input gameState gameSt,
	input logic spriteEn,
	input spriteIdx spriteSel,
	input rowIdx row,
	input wordIdx rdIdx,
	output sramWord rdWord,
	output logic busy,
	output logic lineDone,
	output logic read,
	output sramAddr addr,
	input logic doneR,
	input sramWord readData
);

	localparam wordIdx lastWord = wordIdx'(`WORDS_PER_LINE - 1);

	fetchState state;
	wordIdx wordCnt;
	sramAddr lineBase;
	sramAddr imageBase;
	sramAddr rowBase;
	logic pending;

	// row storage, contents meaningless until first lineDone
	sramWord lineBuf [`WORDS_PER_LINE];

	// image start from game state and sprite choice
	always_comb
	begin
		if (gameSt == gsMenu)
			imageBase = `MENU_BASE;
		else if (spriteEn)
			imageBase = `SPRITE_BASE
				+ sramAddr'(spriteSel) * sramAddr'(`SPRITE_WORDS);
		else
			imageBase = `BG_BASE;
	end

	// rows are packed back to back
	assign rowBase = imageBase + sramAddr'(row) * sramAddr'(`WORDS_PER_LINE);

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= fIdle;
			wordCnt <= '0;
			pending <= 1'b0;
		end
		else
		begin
			unique case (state)
				fIdle:
					// requests while busy never reach here
					if (start)
					begin
						state <= fIssue;
						wordCnt <= '0;
					end
				fIssue:
				begin
					state <= fWait;
					pending <= 1'b1;
				end
				fWait:
					if (doneR)
					begin
						pending <= 1'b0;
						if (wordCnt == lastWord)
							state <= fDone;
						else
						begin
							wordCnt <= wordCnt + 1'b1;
							state <= fIssue;
						end
					end
				fDone:
					state <= fIdle;
				default:
					state <= fIdle;
			endcase
		end
	end

	// base captured once per row
	always_ff @(posedge Clk)
	begin
		if (state == fIdle && start)
			lineBase <= rowBase;
	end

	// store each word as the controller hands it over
	always_ff @(posedge Clk)
	begin
		if (state == fWait && doneR)
			lineBuf[wordCnt] <= readData;
	end

	assign read = (state == fIssue);
	assign addr = lineBase + sramAddr'(wordCnt);
	assign busy = (state != fIdle);
	assign lineDone = (state == fDone);

	// video side lookup, no clock
	assign rdWord = lineBuf[rdIdx];

	// one read in flight at most
	singleRead: assert property (@(posedge Clk) disable iff (rst)
		read |-> !pending);

	// line completes only on the last word's handover
	doneOnLast: assert property (@(posedge Clk) disable iff (rst)
		lineDone |-> $past(doneR) && ($past(wordCnt) == lastWord));

endmodule

`default_nettype wire

// File: verilog/sramController.sv
// ----------------------------------------
// one-word read cycle for the async SRAM
// pulse read with addr, result arrives with doneR
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module sramController
	import sramPkg::*;
(
	input logic Clk,
	input logic rst,
	input logic read,
	input sramAddr addr,
	input sramWord data,
	output logic ce,
	output logic ub,
	output logic lb,
	output logic oe,
	output logic we,
	output sramAddr addrOut,
	output logic doneR,
	output sramWord readData
);

	ctrlState state, nextState;
	logic accept;

	// read only, chip always selected, both bytes
	assign ce = 1'b0;
	assign ub = 1'b0;
	assign lb = 1'b0;
	assign we = 1'b1;

	// new request only taken when idle
	assign accept = (state == ctrlIdle) && read;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= ctrlIdle;
			readData <= '0;
		end
		else
		begin
			state <= nextState;
			// sample the bus at the end of the first oe cycle
			if (state == ctrlRead)
				readData <= data;
		end
	end

	// address held on the pins for the whole cycle
	always_ff @(posedge Clk)
	begin
		if (accept)
			addrOut <= addr;
	end

	always_comb
	begin
		nextState = state;
		unique case (state)
			ctrlIdle:
				if (read)
					nextState = ctrlRead;
			ctrlRead:
				nextState = ctrlDone;
			ctrlDone:
				nextState = ctrlIdle;
			default:
				nextState = ctrlIdle;
		endcase
	end

	// oe low across read and done, done flags a loaded result
	assign oe = !((state == ctrlRead) || (state == ctrlDone));
	assign doneR = (state == ctrlDone);

	// done only two cycles after an accepted read
	doneAfterRead: assert property (@(posedge Clk) disable iff (rst)
		doneR |-> $past(accept, 2));

	// output enable spans exactly two cycles
	oeTwoCycles: assert property (@(posedge Clk) disable iff (rst)
		$fell(oe) |=> !oe ##1 oe);

endmodule

`default_nettype wire

// File: verilog/sramPkg.sv
// ----------------------------------------
// SRAM bus types and read controller states
// ----------------------------------------
`default_nettype none

`include "lightCycle_params.svh"

package sramPkg;

	// word address into the SRAM
	typedef logic [`SRAM_AW-1:0] sramAddr;

	// one 16-bit data word
	typedef logic [`SRAM_DW-1:0] sramWord;

	// single read cycle sequence
	typedef enum logic [1:0]
	{
		ctrlIdle,
		ctrlRead,
		ctrlDone
	} ctrlState;

endpackage

`default_nettype wire
